// File: project.f
source/axi_sram_pkg.sv
source/axi_wr_channel.sv
source/axi_rd_channel.sv
source/sram_port_arb.sv
source/sram_bank.sv
source/axi_sram_top.sv
verif/tb_axi_sram.sv

// File: run_sim.sh
#!/bin/bash
# build and run the AXI SRAM testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tb_axi_sram -o sim_axi_sram
./obj_dir/sim_axi_sram 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished clean"

// File: verif/tb_axi_sram.sv
module tb_axi_sram
	import axi_sram_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYC = 2000;
	localparam int SIG_AWREADY = 0;
	localparam int SIG_WREADY  = 1;
	localparam int SIG_BVALID  = 2;
	localparam int SIG_ARREADY = 3;
	localparam int SIG_RVALID  = 4;
	localparam logic WR = 1'b0;
	localparam logic RD = 1'b1;

	// one table row per burst
	typedef struct packed {
		logic                  rd;
		logic [AXI_ADDR_W-1:0] addr;
		logic [7:0]            len;
		logic [2:0]            size;
		logic [1:0]            burst;
		logic [31:0]           dseed;
		logic                  stall;
		logic                  par;
		axi_resp_t             resp;
	} txn_t;

	logic                    aclk, rst_n;
	logic [AXI_ADDR_W-1:0]   awaddr, araddr;
	logic [7:0]              awlen, arlen;
	logic [2:0]              awsize, arsize;
	logic [1:0]              awburst, arburst;
	logic                    awvalid, awready, arvalid, arready;
	logic [AXI_DATA_W-1:0]   wdata, rdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic                    wlast, wvalid, wready, rlast, rvalid, rready;
	logic                    bvalid, bready;
	axi_resp_t               bresp, rresp;

	// reference memory, one byte per address, aliased at 32 KiB
	logic [7:0] ref_mem [32768];
	txn_t       tbl [$];
	integer     seed;
	int         data_errs, resp_errs, last_errs;
	int         i;

	axi_sram_top #(.WORD_AW(13)) u_dut (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// ====================================================================
	// compare tasks
	task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] got,
		input logic [AXI_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
		if (got !== exp) begin
			$display("error: %s got %h expected %h", name, got, exp);
			resp_errs++;
		end
	endtask

	task automatic check_last(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: rlast got %h expected %h", got, exp);
			last_errs++;
		end
	endtask

	// ====================================================================
	// handshake helpers
	function automatic logic sig_high(input int sel);
		case (sel)
			SIG_AWREADY: return awready;
			SIG_WREADY:  return wready;
			SIG_BVALID:  return bvalid;
			SIG_ARREADY: return arready;
			default:     return rvalid;
		endcase
	endfunction

	// sampled on the falling edge, away from the driving edge
	task automatic wait_for(input int sel, input string what);
		int n;
		n = 0;
		@(negedge aclk);
		while (!sig_high(sel) && n < TIMEOUT_CYC) begin
			n++;
			@(negedge aclk);
		end
		if (!sig_high(sel)) begin
			$display("timed out after %0d cycles waiting for %s", TIMEOUT_CYC, what);
			$display("tests failed");
			$finish;
		end
	endtask

	// 0 to 3 idle cycles before a ready
	task automatic random_delay(input logic stall);
		if (stall)
			repeat ($unsigned($random(seed)) % 4) @(posedge aclk);
	endtask

	// ====================================================================
	// bus master
	task automatic write_burst(input txn_t t);
		logic [15:0] a;
		logic [31:0] d;
		logic [3:0]  be;
		int          nbeats;
		a      = t.addr[15:0];
		nbeats = int'(t.len) + 1;
		@(posedge aclk);
		awaddr  <= t.addr;
		awlen   <= t.len;
		awsize  <= t.size;
		awburst <= t.burst;
		awvalid <= 1'b1;
		wait_for(SIG_AWREADY, "awready");
		@(posedge aclk);
		awvalid <= 1'b0;
		for (int b = 0; b < nbeats; b++) begin
			// seed 0 means random data
			d = (t.dseed == 32'd0) ? $random(seed) : t.dseed + b * 32'h0102_0304;
			wdata  <= d;
			wstrb  <= lane_enables(t.size, a[1:0]);
			wlast  <= (b == nbeats - 1);
			wvalid <= 1'b1;
			wait_for(SIG_WREADY, "wready");
			@(posedge aclk);
			// memory only moves on a legal burst
			if (t.resp == OKAY) begin
				be = lane_enables(t.size, a[1:0]);
				for (int l = 0; l < 4; l++)
					if (be[l])
						ref_mem[{a[14:2], l[1:0]}] = d[8*l +: 8];
			end
			if (t.burst == INCR)
				a = a + (16'd1 << t.size);
		end
		wvalid <= 1'b0;
		wlast  <= 1'b0;
		wait_for(SIG_BVALID, "bvalid");
		check_resp("bresp", bresp, t.resp);
		random_delay(t.stall);
		@(posedge aclk);
		bready <= 1'b1;
		@(posedge aclk);
		bready <= 1'b0;
	endtask

	task automatic read_burst(input txn_t t);
		logic [15:0]           a;
		logic [AXI_DATA_W-1:0] exp_d;
		int                    nbeats;
		a      = t.addr[15:0];
		nbeats = int'(t.len) + 1;
		@(posedge aclk);
		araddr  <= t.addr;
		arlen   <= t.len;
		arsize  <= t.size;
		arburst <= t.burst;
		arvalid <= 1'b1;
		wait_for(SIG_ARREADY, "arready");
		@(posedge aclk);
		arvalid <= 1'b0;
		for (int b = 0; b < nbeats; b++) begin
			// full word back, zero on slverr
			exp_d = '0;
			if (t.resp == OKAY)
				for (int l = 0; l < 4; l++)
					exp_d[8*l +: 8] = ref_mem[{a[14:2], l[1:0]}];
			wait_for(SIG_RVALID, "rvalid");
			check_data("rdata", rdata, exp_d);
			check_resp("rresp", rresp, t.resp);
			check_last(rlast, b == nbeats - 1);
			random_delay(t.stall);
			@(posedge aclk);
			rready <= 1'b1;
			@(posedge aclk);
			rready <= 1'b0;
			if (t.burst == INCR)
				a = a + (16'd1 << t.size);
		end
	endtask

	task automatic run_txn(input txn_t t);
		if (t.rd)
			read_burst(t);
		else
			write_burst(t);
	endtask

	// ====================================================================
	// transaction table
	task automatic add_txn(input logic rd, input logic [31:0] addr, input logic [7:0] len,
		input logic [2:0] size, input logic [1:0] burst, input logic [31:0] dseed,
		input logic stall, input logic par, input axi_resp_t resp);
		txn_t t;
		t = '{rd, addr, len, size, burst, dseed, stall, par, resp};
		tbl.push_back(t);
	endtask

	task automatic load_table();
		// dir  address       awlen size burst  data seed     stall par  response
		add_txn(WR, 32'h0000_0000, 7, 2, INCR, 32'h1000_0000, 0, 0, OKAY);
		add_txn(RD, 32'h0000_0000, 7, 2, INCR, 32'd0, 0, 0, OKAY);
		add_txn(WR, 32'h0000_0100, 255, 2, INCR, 32'd0, 0, 0, OKAY);
		add_txn(RD, 32'h0000_0100, 255, 2, INCR, 32'd0, 0, 0, OKAY);
		// narrow writes into words already filled
		add_txn(WR, 32'h0000_0010, 3, 0, INCR, 32'hA5A5_0000, 0, 0, OKAY);
		add_txn(WR, 32'h0000_0016, 0, 1, INCR, 32'h5A5A_1234, 0, 0, OKAY);
		add_txn(RD, 32'h0000_0010, 3, 2, INCR, 32'd0, 0, 0, OKAY);
		// fixed bursts, last beat wins
		add_txn(WR, 32'h0000_0200, 5, 2, FIXED, 32'h7700_0000, 0, 0, OKAY);
		add_txn(WR, 32'h0000_0205, 3, 0, FIXED, 32'h1122_3344, 0, 0, OKAY);
		add_txn(RD, 32'h0000_0200, 1, 2, INCR, 32'd0, 0, 0, OKAY);
		// wrap, reserved and 8-byte beats
		add_txn(WR, 32'h0000_0300, 3, 2, WRAP, 32'hDEAD_0000, 0, 0, SLVERR);
		add_txn(WR, 32'h0000_0300, 1, 2, RSVD, 32'hDEAD_1000, 0, 0, SLVERR);
		add_txn(WR, 32'h0000_0300, 1, 3, INCR, 32'hDEAD_2000, 0, 0, SLVERR);
		add_txn(RD, 32'h0000_0300, 3, 2, WRAP, 32'd0, 0, 0, SLVERR);
		add_txn(RD, 32'h0000_0300, 0, 2, RSVD, 32'd0, 0, 0, SLVERR);
		add_txn(RD, 32'h0000_0300, 1, 3, INCR, 32'd0, 0, 0, SLVERR);
		add_txn(RD, 32'h0000_0300, 3, 2, INCR, 32'd0, 0, 0, OKAY);
		// overlapping pairs with ready stalls
		add_txn(WR, 32'h0000_0400, 15, 2, INCR, 32'd0, 1, 1, OKAY);
		add_txn(RD, 32'h0000_0100, 31, 2, INCR, 32'd0, 1, 0, OKAY);
		add_txn(WR, 32'h0000_0010, 7, 1, INCR, 32'd0, 1, 1, OKAY);
		add_txn(RD, 32'h0000_0400, 15, 2, INCR, 32'd0, 1, 0, OKAY);
		add_txn(RD, 32'h0000_0010, 3, 2, INCR, 32'd0, 1, 0, OKAY);
		// upper address bits alias
		add_txn(WR, 32'h0001_8020, 0, 2, INCR, 32'hCAFE_F00D, 0, 0, OKAY);
		add_txn(RD, 32'h0000_0020, 0, 2, INCR, 32'd0, 0, 0, OKAY);
		add_txn(RD, 32'hFFFF_8020, 0, 2, INCR, 32'd0, 0, 0, OKAY);
	endtask

	// ====================================================================
	initial begin
		seed      = 32'h94bca8dd;
		data_errs = 0;
		resp_errs = 0;
		last_errs = 0;
		rst_n     = 1'b0;
		awaddr    = '0;
		awlen     = '0;
		awsize    = '0;
		awburst   = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wlast     = 1'b0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arlen     = '0;
		arsize    = '0;
		arburst   = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		load_table();
		repeat (3) @(posedge aclk);
		rst_n <= 1'b1;

		// par marks a row that runs alongside the next one
		i = 0;
		while (i < tbl.size()) begin
			if (tbl[i].par && i + 1 < tbl.size()) begin
				fork
					run_txn(tbl[i]);
					run_txn(tbl[i+1]);
				join
				i += 2;
			end else begin
				run_txn(tbl[i]);
				i++;
			end
		end

		repeat (2) @(posedge aclk);
		$display("data errors %0d, response errors %0d, rlast errors %0d",
			data_errs, resp_errs, last_errs);
		if (data_errs + resp_errs + last_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: source/axi_sram_top.sv
module axi_sram_top
	import axi_sram_pkg::*;
#(
	parameter int WORD_AW = 13
) (
	input  logic                    aclk,
	input  logic                    rst_n,
	// write address
	input  logic [AXI_ADDR_W-1:0]   awaddr,
	input  logic [7:0]              awlen,
	input  logic [2:0]              awsize,
	input  logic [1:0]              awburst,
	input  logic                    awvalid,
	output logic                    awready,
	// write data
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wlast,
	input  logic                    wvalid,
	output logic                    wready,
	// write response
	output axi_resp_t               bresp,
	output logic                    bvalid,
	input  logic                    bready,
	// read address
	input  logic [AXI_ADDR_W-1:0]   araddr,
	input  logic [7:0]              arlen,
	input  logic [2:0]              arsize,
	input  logic [1:0]              arburst,
	input  logic                    arvalid,
	output logic                    arready,
	// read data
	output logic [AXI_DATA_W-1:0]   rdata,
	output axi_resp_t               rresp,
	output logic                    rlast,
	output logic                    rvalid,
	input  logic                    rready
);

	// ====================================================================
	// channel to arbiter
	logic                  wr_req, wr_gnt;
	sram_addr_u            wr_addr;
	logic [2:0]            wr_size;
	logic [AXI_DATA_W-1:0] wr_data;
	logic                  rd_req, rd_gnt;
	sram_addr_u            rd_addr;
	logic [2:0]            rd_size;

	// arbiter to bank
	logic                  sram_we;
	logic [WORD_AW-1:0]    sram_word;
	logic [3:0]            sram_be;
	logic [AXI_DATA_W-1:0] sram_wdata;
	logic [AXI_DATA_W-1:0] sram_q;

	// ====================================================================
	// front ends
	axi_wr_channel u_wr_channel (.*);

	axi_rd_channel u_rd_channel (.*, .sram_rdata(sram_q));

	// shared port and memory
	sram_port_arb #(.WORD_AW(WORD_AW)) u_port_arb (.*);

	sram_bank #(.WORD_AW(WORD_AW)) u_bank (.*);

endmodule

// File: source/sram_bank.sv
module sram_bank
	import axi_sram_pkg::*;
#(
	parameter int WORD_AW = 13
) (
	input  logic                  aclk,
	input  logic                  sram_we,
	input  logic [WORD_AW-1:0]    sram_word,
	input  logic [3:0]            sram_be,
	input  logic [AXI_DATA_W-1:0] sram_wdata,
	output logic [AXI_DATA_W-1:0] sram_q
);

	localparam int DEPTH = 2 ** WORD_AW;

	// one output register per chip
	logic [7:0] lane_q [4];

	// ====================================================================
	// four byte-wide chips on a shared word address
	for (genvar i = 0; i < 4; i++) begin : g_lane
		logic [7:0] mem [DEPTH];

		always_ff @(posedge aclk) begin
			if (sram_we && sram_be[i])
				mem[sram_word] <= sram_wdata[8*i +: 8];
			// read every cycle, old data on a write
			lane_q[i] <= mem[sram_word];
		end
	end

	// lane 0 is the low byte
	assign sram_q = {lane_q[3], lane_q[2], lane_q[1], lane_q[0]};

endmodule

// File: source/sram_port_arb.sv
module sram_port_arb
	import axi_sram_pkg::*;
#(
	parameter int WORD_AW = 13
) (
	input  logic                  aclk,
	input  logic                  rst_n,
	// write channel side
	input  logic                  wr_req,
	output logic                  wr_gnt,
	input  sram_addr_u            wr_addr,
	input  logic [2:0]            wr_size,
	input  logic [AXI_DATA_W-1:0] wr_data,
	// read channel side
	input  logic                  rd_req,
	output logic                  rd_gnt,
	input  sram_addr_u            rd_addr,
	input  logic [2:0]            rd_size,
	// single sram port
	output logic                  sram_we,
	output logic [WORD_AW-1:0]    sram_word,
	output logic [3:0]            sram_be,
	output logic [AXI_DATA_W-1:0] sram_wdata
);

	sram_addr_u sel_addr;
	logic [2:0] sel_size;

	// ====================================================================
	// write first with the grant consumed the same cycle
	assign wr_gnt = wr_req;
	assign rd_gnt = rd_req && !wr_req;

	// port mux
	assign sel_addr = wr_req ? wr_addr : rd_addr;
	assign sel_size = wr_req ? wr_size : rd_size;

	// ====================================================================
	// sram side decode
	assign sram_we    = wr_gnt;
	// bank_bit dropped so addresses alias every 32 KiB
	assign sram_word  = sel_addr.f.word[WORD_AW-1:0];
	assign sram_be    = lane_enables(sel_size, sel_addr.f.lane);
	// bytes already sit on their own lanes
	assign sram_wdata = wr_data;

	// ====================================================================
	// channels filter bad sizes so a write always hits some lane
	a_we_has_lanes: assert property (@(posedge aclk) disable iff (!rst_n)
		sram_we |-> sram_be != 4'b0000);

endmodule

// File: source/axi_rd_channel.sv
module axi_rd_channel
	import axi_sram_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst_n,
	// read address
	input  logic [AXI_ADDR_W-1:0] araddr,
	input  logic [7:0]            arlen,
	input  logic [2:0]            arsize,
	input  logic [1:0]            arburst,
	input  logic                  arvalid,
	output logic                  arready,
	// read data
	output logic [AXI_DATA_W-1:0] rdata,
	output axi_resp_t             rresp,
	output logic                  rlast,
	output logic                  rvalid,
	input  logic                  rready,
	// sram port request
	output logic                  rd_req,
	input  logic                  rd_gnt,
	output sram_addr_u            rd_addr,
	output logic [2:0]            rd_size,
	input  logic [AXI_DATA_W-1:0] sram_rdata
);

	typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_HOLD} rd_state_t;

	rd_state_t             state;
	sram_addr_u            addr_q;
	logic [2:0]            size_q;
	logic                  incr_q;
	logic                  legal_q;
	logic [7:0]            beats_left;
	logic [AXI_DATA_W-1:0] rdata_q;
	logic                  ar_fire;
	logic                  r_fire;

	// ====================================================================
	// handshakes
	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	assign arready = (state == RD_IDLE);
	// one request in flight, none while a beat waits on rready
	assign rd_req  = (state == RD_REQ) && legal_q;
	assign rvalid  = (state == RD_HOLD);
	assign rlast   = (beats_left == 8'd0);
	assign rresp   = legal_q ? OKAY : SLVERR;
	assign rdata   = rdata_q;

	assign rd_addr = addr_q;
	assign rd_size = size_q;

	// ====================================================================
	// channel fsm
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: if (ar_fire) state <= RD_REQ;
				// illegal beats skip the sram
				RD_REQ:  if (!legal_q) state <= RD_HOLD;
				         else if (rd_gnt) state <= RD_WAIT;
				// bank output valid this cycle
				RD_WAIT: state <= RD_HOLD;
				RD_HOLD: if (rready) state <= rlast ? RD_IDLE : RD_REQ;
				default: state <= RD_IDLE;
			endcase
		end
	end

	// burst context and holding register
	always_ff @(posedge aclk) begin
		if (ar_fire) begin
			addr_q.raw <= araddr[15:0];
			size_q     <= arsize;
			incr_q     <= (arburst == INCR);
			legal_q    <= size_ok(arsize) && burst_ok(arburst);
			beats_left <= arlen;
		end else if (r_fire) begin
			if (incr_q)
				addr_q.raw <= addr_q.raw + (16'd1 << size_q);
			beats_left <= beats_left - 8'd1;
		end
		// zero data goes with slverr
		if (state == RD_REQ && !legal_q)
			rdata_q <= '0;
		else if (state == RD_WAIT)
			rdata_q <= sram_rdata;
	end

	// ====================================================================
	a_r_stable: assert property (@(posedge aclk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
			&& $stable(rlast));

endmodule

// File: source/axi_wr_channel.sv
module axi_wr_channel
	import axi_sram_pkg::*;
(
	input  logic                    aclk,
	input  logic                    rst_n,
	// write address
	input  logic [AXI_ADDR_W-1:0]   awaddr,
	input  logic [7:0]              awlen,
	input  logic [2:0]              awsize,
	input  logic [1:0]              awburst,
	input  logic                    awvalid,
	output logic                    awready,
	// write data
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wlast,
	input  logic                    wvalid,
	output logic                    wready,
	// write response
	output axi_resp_t               bresp,
	output logic                    bvalid,
	input  logic                    bready,
	// sram port request
	output logic                    wr_req,
	input  logic                    wr_gnt,
	output sram_addr_u              wr_addr,
	output logic [2:0]              wr_size,
	output logic [AXI_DATA_W-1:0]   wr_data
);

	typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

	wr_state_t  state;
	sram_addr_u addr_q;
	logic [2:0] size_q;
	logic       incr_q;
	logic       legal_q;
	logic [7:0] beats_left;
	logic       aw_fire;
	logic       w_fire;

	// ====================================================================
	// handshakes
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	assign awready = (state == WR_IDLE);
	// a legal beat needs the port while an illegal beat is drained
	assign wr_req  = (state == WR_DATA) && legal_q && wvalid;
	assign wready  = (state == WR_DATA) && (legal_q ? wr_gnt : 1'b1);
	assign bvalid  = (state == WR_RESP);
	assign bresp   = legal_q ? OKAY : SLVERR;

	// lanes come from size and address and wstrb is not decoded
	assign wr_addr = addr_q;
	assign wr_size = size_q;
	assign wr_data = wdata;

	// ====================================================================
	// channel fsm
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: if (aw_fire) state <= WR_DATA;
				WR_DATA: if (w_fire && wlast) state <= WR_RESP;
				WR_RESP: if (bready) state <= WR_IDLE;
				default: state <= WR_IDLE;
			endcase
		end
	end

	// burst context stepped per accepted beat
	always_ff @(posedge aclk) begin
		if (aw_fire) begin
			addr_q.raw <= awaddr[15:0];
			size_q     <= awsize;
			incr_q     <= (awburst == INCR);
			legal_q    <= size_ok(awsize) && burst_ok(awburst);
			beats_left <= awlen;
		end else if (w_fire) begin
			// fixed keeps the address
			if (incr_q)
				addr_q.raw <= addr_q.raw + (16'd1 << size_q);
			beats_left <= beats_left - 8'd1;
		end
	end

	// ====================================================================
	a_bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

	// master must end on the beat awlen announced
	a_wlast_len: assert property (@(posedge aclk) disable iff (!rst_n)
		w_fire |-> wlast == (beats_left == 8'd0));

endmodule

// File: source/axi_sram_pkg.sv
package axi_sram_pkg;

	// bus widths, four byte lanes fixed by the sram chips
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10,
		RSVD  = 2'b11
	} axi_burst_t;

	// low 16 bits of the byte address, raw or split
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic        bank_bit;  // second bank not fitted, ignored
			logic [12:0] word;
			logic [1:0]  lane;
		} f;
	} sram_addr_u;

	// byte lanes touched by one beat
	function automatic logic [3:0] lane_enables(input logic [2:0] size, input logic [1:0] lane);
		case (size)
			3'd0:    return 4'b0001 << lane;
			3'd1:    return lane[1] ? 4'b1100 : 4'b0011;
			3'd2:    return 4'b1111;
			default: return 4'b0000;
		endcase
	endfunction

	// up to 4 bytes per beat
	function automatic logic size_ok(input logic [2:0] size);
		return size <= 3'd2;
	endfunction

	// wrap and reserved end in slverr
	function automatic logic burst_ok(input logic [1:0] burst);
		return (burst == FIXED) || (burst == INCR);
	endfunction

endpackage
